// ==== common/m2v_ctrl_cfg.svh ====
// ------------------------------------------------------------
// MPEG-2 decode controller configuration
// Field widths, I/O addresses and register bit positions
// ------------------------------------------------------------
`ifndef M2V_CTRL_CFG_SVH
`define M2V_CTRL_CFG_SVH

// Macroblock position widths
`define M2V_MBX_WIDTH 6
`define M2V_MBY_WIDTH 5
`define M2V_MBX_ADDER 6
`define M2V_MVH_WIDTH 16

// I/O command addresses (B operand, low nibble)
`define M2V_IO_CONTROL   4'd1
`define M2V_IO_VIDEOINFO 4'd2
`define M2V_IO_MAX_MBXY  4'd3
`define M2V_IO_QMATRIX   4'd4
`define M2V_IO_SLICEVERT 4'd5
`define M2V_IO_QSCODE    4'd6
`define M2V_IO_MB_ADDR   4'd7
`define M2V_IO_MB_QSCODE 4'd8

// Control word bits, shared by commands and host status
`define M2V_CN_BLK_START 0
`define M2V_CN_BLK_END   2
`define M2V_CN_IRQ_SEQ   3
`define M2V_CN_IRQ_PIC   4
`define M2V_CN_PAUSE     5
`define M2V_CN_ERROR     6
`define M2V_CN_SOFTRESET 7

// Video info field selects
`define M2V_VI_WIDTH  13
`define M2V_VI_HEIGHT 14
`define M2V_VI_FRATE  15

// Quantiser matrix and quantiser code flags
`define M2V_QM_INTRA  8
`define M2V_QM_CUSTOM 9
`define M2V_QC_SLICE  5
`define M2V_QC_COPY   6

`endif

// ==== common/m2v_ctrl_pkg.sv ====
// ------------------------------------------------------------
// MPEG-2 decode controller shared types
// Operand words, macroblock fields and the I/O command word
// ------------------------------------------------------------
`include "m2v_ctrl_cfg.svh"

package m2v_ctrl_pkg;

	typedef logic [15:0] word16_t;
	typedef logic [3:0]  io_addr_t;

	typedef logic [`M2V_MBX_WIDTH-1:0] mbx_t;
	typedef logic [`M2V_MBY_WIDTH-1:0] mby_t;
	typedef logic [4:0]                qscode_t;

	// ----------------------------------------------------------
	// B operand of an I/O command
	// ----------------------------------------------------------

	// Register access view
	typedef struct packed {
		logic [11:0] rsvd;
		io_addr_t    addr;
	} io_reg_op_t;

	// Side information view for stage 1
	typedef struct packed {
		logic [6:0] rsvd;
		logic       side;
		logic       mb_valid;
		logic       mvec_v;
		logic       mvec_h;
		logic       pict;
		logic [3:0] rsvd_lo;
	} io_side_op_t;

	typedef union packed {
		io_reg_op_t  reg_op;
		io_side_op_t side_op;
	} io_cmd_u;

endpackage

// ==== design/m2v_cmd_decode.sv ====
// ------------------------------------------------------------
// MPEG-2 decode controller command decoder
// Captures custom-instruction commands, drives the per-address
// write strobes and stage strobes, forms the command result
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "m2v_ctrl_cfg.svh"

module m2v_cmd_decode (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  custom_start,
	input  logic [2:0]            custom_select,
	input  m2v_ctrl_pkg::word16_t custom_adata,
	input  m2v_ctrl_pkg::word16_t custom_bdata,
	input  logic                  pause,
	input  logic                  mb_wait,
	input  logic                  ready_isdq,
	input  logic                  ready_idct,
	input  logic                  ready_mc,
	input  logic [2:0]            s1_block,
	input  logic                  s1_coded,
	output logic                  custom_done,
	output m2v_ctrl_pkg::word16_t custom_result,
	output m2v_ctrl_pkg::word16_t adata,
	output logic                  wr_control,
	output logic                  wr_videoinfo,
	output logic                  wr_max_mbxy,
	output logic                  wr_qmatrix,
	output logic                  wr_slicevert,
	output logic                  wr_qscode,
	output logic                  wr_mb_addr,
	output logic                  pict_valid,
	output logic                  mvec_h_valid,
	output logic                  mvec_v_valid,
	output logic                  s0_valid,
	output logic                  rl_valid,
	output logic [5:0]            run
);
	import m2v_ctrl_pkg::*;

	word16_t  adata_q;
	word16_t  bdata_q;
	logic     io_stb_q;
	logic     rl_stb_q;
	logic     io_start;
	logic     rl_start;
	io_cmd_u  cmd;
	logic     reg_stb;
	logic     side_stb;
	io_addr_t addr;

	// Only I/O commands and run/level pairs are accepted
	assign io_start = custom_start & custom_select[2];
	assign rl_start = custom_start & (custom_select == 3'd0);

	always_ff @(posedge clk) begin
		if (io_start | rl_start) begin
			adata_q <= custom_adata;
			bdata_q <= custom_bdata;
		end
	end

	// One-cycle command strobes, also the done pulse
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			io_stb_q <= 1'b0;
			rl_stb_q <= 1'b0;
		end else begin
			io_stb_q <= io_start;
			rl_stb_q <= rl_start;
		end
	end

	assign custom_done = io_stb_q | rl_stb_q;
	assign adata       = adata_q;

	// ----------------------------------------------------------
	// B operand decode
	// ----------------------------------------------------------
	assign cmd      = bdata_q;
	assign addr     = cmd.reg_op.addr;
	assign side_stb = io_stb_q & cmd.side_op.side;
	assign reg_stb  = io_stb_q & ~cmd.side_op.side;

	assign wr_control   = reg_stb & (addr == `M2V_IO_CONTROL);
	assign wr_videoinfo = reg_stb & (addr == `M2V_IO_VIDEOINFO);
	assign wr_max_mbxy  = reg_stb & (addr == `M2V_IO_MAX_MBXY);
	assign wr_qmatrix   = reg_stb & (addr == `M2V_IO_QMATRIX);
	assign wr_slicevert = reg_stb & (addr == `M2V_IO_SLICEVERT);
	assign wr_qscode    = reg_stb & (addr == `M2V_IO_QSCODE);
	assign wr_mb_addr   = reg_stb & (addr == `M2V_IO_MB_ADDR);

	// Stage 1 side information
	assign pict_valid   = side_stb & cmd.side_op.pict;
	assign mvec_h_valid = side_stb & cmd.side_op.mvec_h;
	assign mvec_v_valid = side_stb & cmd.side_op.mvec_v;
	assign s0_valid     = side_stb & cmd.side_op.mb_valid;

	// Direct run/level pair
	assign rl_valid = rl_stb_q;
	assign run      = bdata_q[5:0];

	// ----------------------------------------------------------
	// Command result
	// ----------------------------------------------------------
	always_comb begin
		custom_result = '0;
		if (io_stb_q) begin
			case (addr)
				`M2V_IO_MB_ADDR: custom_result = {15'd0, mb_wait};
				// Run/level engine always reads stopped, never escape
				`M2V_IO_CONTROL: custom_result = {6'd0, ~pause, s1_block, ready_mc,
					ready_idct, ready_isdq, 1'b1, 1'b0, s1_coded};
				default: custom_result = '0;
			endcase
		end
	end

endmodule

// ==== design/m2v_host_regs.sv ====
// ------------------------------------------------------------
// MPEG-2 decode controller host registers
// Status and video info readback, interrupt flags, soft reset
// and the block and picture strobes to all stages
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "m2v_ctrl_cfg.svh"

module m2v_host_regs (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  control_address,
	input  logic                  control_read,
	input  logic                  control_write,
	input  logic [31:0]           control_writedata,
	input  logic                  wr_control,
	input  logic                  wr_videoinfo,
	input  m2v_ctrl_pkg::word16_t adata,
	output logic [31:0]           control_readdata,
	output logic                  control_readdatavalid,
	output logic                  irq,
	output logic                  pause,
	output logic                  softreset,
	output logic                  block_start,
	output logic                  block_end,
	output logic                  picture_complete
);

	logic        host_wr_status;
	logic        pic_set;
	logic        irq_seq_q;
	logic        irq_pic_q;
	logic        pause_q;
	logic        error_q;
	logic        softreset_q;
	logic [7:0]  pictures_q;
	logic [9:0]  width_q;
	logic [9:0]  height_q;
	logic [3:0]  frate_q;
	logic        rd_addr_q;
	logic        rd_valid_q;
	logic [31:0] status;
	logic [31:0] video;

	assign host_wr_status = control_write & ~control_address;
	assign pic_set        = wr_control & adata[`M2V_CN_IRQ_PIC];

	// ----------------------------------------------------------
	// Control flags
	// ----------------------------------------------------------

	// Host write-one-to-clear wins over a command set
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			irq_seq_q <= 1'b0;
			irq_pic_q <= 1'b0;
			pause_q   <= 1'b0;
			error_q   <= 1'b0;
		end else begin
			if (host_wr_status & control_writedata[`M2V_CN_IRQ_SEQ])
				irq_seq_q <= 1'b0;
			else if (wr_control & adata[`M2V_CN_IRQ_SEQ])
				irq_seq_q <= 1'b1;
			if (host_wr_status & control_writedata[`M2V_CN_IRQ_PIC])
				irq_pic_q <= 1'b0;
			else if (pic_set)
				irq_pic_q <= 1'b1;
			if (host_wr_status & control_writedata[`M2V_CN_PAUSE])
				pause_q <= 1'b0;
			else if (pic_set)
				pause_q <= 1'b1;
			if (host_wr_status & control_writedata[`M2V_CN_ERROR])
				error_q <= 1'b0;
			else if (wr_control & adata[`M2V_CN_ERROR])
				error_q <= 1'b1;
		end
	end

	// Decoder comes out of reset held in soft reset
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			softreset_q <= 1'b1;
			pictures_q  <= '0;
		end else begin
			if (host_wr_status)
				softreset_q <= control_writedata[`M2V_CN_SOFTRESET];
			if (softreset_q)
				pictures_q <= '0;
			else if (pic_set)
				pictures_q <= pictures_q + 8'd1;
		end
	end

	assign irq              = irq_seq_q | irq_pic_q;
	assign pause            = pause_q;
	assign softreset        = softreset_q;
	assign block_start      = wr_control & adata[`M2V_CN_BLK_START];
	assign block_end        = wr_control & adata[`M2V_CN_BLK_END];
	assign picture_complete = pic_set;

	// ----------------------------------------------------------
	// Video info
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			width_q  <= '0;
			height_q <= '0;
			frate_q  <= '0;
		end else if (wr_videoinfo) begin
			if (adata[`M2V_VI_WIDTH])
				width_q <= adata[9:0];
			if (adata[`M2V_VI_HEIGHT])
				height_q <= adata[9:0];
			if (adata[`M2V_VI_FRATE])
				frate_q <= adata[3:0];
		end
	end

	// ----------------------------------------------------------
	// Host readback, one cycle latency
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_addr_q  <= 1'b0;
			rd_valid_q <= 1'b0;
		end else begin
			rd_addr_q  <= control_address;
			rd_valid_q <= control_read;
		end
	end

	always_comb begin
		status                  = '0;
		status[31:24]           = pictures_q;
		status[`M2V_CN_IRQ_SEQ] = irq_seq_q;
		status[`M2V_CN_IRQ_PIC] = irq_pic_q;
		status[`M2V_CN_PAUSE]   = pause_q;
		status[`M2V_CN_ERROR]   = error_q;
	end

	assign video = {frate_q, 8'd0, height_q, width_q};

	assign control_readdata      = rd_addr_q ? video : status;
	assign control_readdatavalid = rd_valid_q;

endmodule

// ==== design/m2v_mb_state.sv ====
// ------------------------------------------------------------
// MPEG-2 decode controller macroblock state
// Position counter with wrap-around and quantiser scale codes
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "m2v_ctrl_cfg.svh"

module m2v_mb_state (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  wr_max_mbxy,
	input  logic                  wr_slicevert,
	input  logic                  wr_mb_addr,
	input  logic                  wr_qscode,
	input  m2v_ctrl_pkg::word16_t adata,
	output m2v_ctrl_pkg::mbx_t    mb_x,
	output m2v_ctrl_pkg::mby_t    mb_y,
	output m2v_ctrl_pkg::qscode_t mb_qscode,
	output logic                  mb_wait
);
	import m2v_ctrl_pkg::*;

	mbx_t                      last_x;
	mby_t                      last_y;
	logic [`M2V_MBX_ADDER-1:0] cur_x;
	mby_t                      cur_y;
	logic [`M2V_MBX_ADDER:0]   last_x_wide;
	logic [`M2V_MBX_ADDER:0]   inc_sum;
	logic [`M2V_MBX_ADDER:0]   wrap_sum;
	qscode_t                   slice_qs;
	qscode_t                   mb_qs;

	assign last_x_wide = {{(`M2V_MBX_ADDER - `M2V_MBX_WIDTH + 1){1'b0}}, last_x};
	assign inc_sum     = {1'b0, cur_x} + {{(`M2V_MBX_ADDER - 5){1'b0}}, adata[5:0]};

	// x - (last + 1), the top bit clears once x is past the last column
	assign wrap_sum = {1'b0, cur_x} + ~last_x_wide;
	assign mb_wait  = ~wrap_sum[`M2V_MBX_ADDER];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			last_x <= '0;
			last_y <= '0;
		end else if (wr_max_mbxy) begin
			last_x <= adata[`M2V_MBX_WIDTH-1:0];
			last_y <= adata[`M2V_MBY_WIDTH+7:8];
		end
	end

	// Wrap one row per idle clock; rows restart after the last one
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cur_x <= '0;
			cur_y <= '0;
		end else if (wr_slicevert) begin
			cur_x <= last_x_wide[`M2V_MBX_ADDER-1:0];
			cur_y <= adata[`M2V_MBY_WIDTH-1:0];
		end else if (wr_mb_addr) begin
			cur_x <= inc_sum[`M2V_MBX_ADDER-1:0];
		end else if (mb_wait) begin
			cur_x <= wrap_sum[`M2V_MBX_ADDER-1:0];
			cur_y <= (cur_y == last_y) ? '0 : cur_y + 1'b1;
		end
	end

	// Quantiser scale codes
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			slice_qs <= '0;
			mb_qs    <= '0;
		end else if (wr_qscode) begin
			if (adata[`M2V_QC_COPY])
				mb_qs <= slice_qs;
			else if (!adata[`M2V_QC_SLICE])
				mb_qs <= adata[4:0];
			if (adata[`M2V_QC_SLICE])
				slice_qs <= adata[4:0];
		end
	end

	assign mb_x      = cur_x[`M2V_MBX_WIDTH-1:0];
	assign mb_y      = cur_y;
	assign mb_qscode = mb_qs;

endmodule

// ==== design/m2v_ctrl.sv ====
// ------------------------------------------------------------
// MPEG-2 video decode controller, register and command layer
// Connects the command decoder, host registers and macroblock state
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "m2v_ctrl_cfg.svh"

module m2v_ctrl (
	input  logic                       clk,
	input  logic                       reset_n,
	// Host control port
	input  logic                       control_address,
	input  logic                       control_read,
	output logic [31:0]                control_readdata,
	input  logic                       control_write,
	input  logic [31:0]                control_writedata,
	output logic                       control_readdatavalid,
	output logic                       irq,
	// Command port
	input  logic                       custom_start,
	input  logic [2:0]                 custom_select,
	input  m2v_ctrl_pkg::word16_t      custom_adata,
	input  m2v_ctrl_pkg::word16_t      custom_bdata,
	output logic                       custom_done,
	output m2v_ctrl_pkg::word16_t      custom_result,
	// Stage 1 side information
	output logic [`M2V_MVH_WIDTH-1:0]  s0_data,
	output logic                       pict_valid,
	output logic                       mvec_h_valid,
	output logic                       mvec_v_valid,
	output logic                       s0_valid,
	output m2v_ctrl_pkg::mbx_t         s0_mb_x,
	output m2v_ctrl_pkg::mby_t         s0_mb_y,
	output m2v_ctrl_pkg::qscode_t      s0_mb_qscode,
	input  logic [2:0]                 s1_block,
	input  logic                       s1_coded,
	// Inverse scan and dequantiser
	input  logic                       ready_isdq,
	output logic [5:0]                 run,
	output logic                       level_sign,
	output logic [10:0]                level_data,
	output logic                       rl_valid,
	output logic                       qm_valid,
	output logic                       qm_custom,
	output logic                       qm_intra,
	output logic [7:0]                 qm_value,
	// Later stages
	input  logic                       ready_idct,
	input  logic                       ready_mc,
	output logic                       softreset,
	output logic                       block_start,
	output logic                       block_end,
	output logic                       picture_complete
);
	import m2v_ctrl_pkg::*;

	word16_t adata;
	logic    pause;
	logic    mb_wait;
	logic    wr_control;
	logic    wr_videoinfo;
	logic    wr_max_mbxy;
	logic    wr_qmatrix;
	logic    wr_slicevert;
	logic    wr_qscode;
	logic    wr_mb_addr;

	m2v_cmd_decode m2v_cmd_decode_i (
		.clk, .reset_n,
		.custom_start, .custom_select, .custom_adata, .custom_bdata,
		.pause, .mb_wait,
		.ready_isdq, .ready_idct, .ready_mc, .s1_block, .s1_coded,
		.custom_done, .custom_result, .adata,
		.wr_control, .wr_videoinfo, .wr_max_mbxy, .wr_qmatrix,
		.wr_slicevert, .wr_qscode, .wr_mb_addr,
		.pict_valid, .mvec_h_valid, .mvec_v_valid, .s0_valid,
		.rl_valid, .run
	);

	m2v_host_regs m2v_host_regs_i (
		.clk, .reset_n,
		.control_address, .control_read, .control_write, .control_writedata,
		.wr_control, .wr_videoinfo, .adata,
		.control_readdata, .control_readdatavalid,
		.irq, .pause, .softreset, .block_start, .block_end, .picture_complete
	);

	m2v_mb_state m2v_mb_state_i (
		.clk, .reset_n,
		.wr_max_mbxy, .wr_slicevert, .wr_mb_addr, .wr_qscode, .adata,
		.mb_x      (s0_mb_x),
		.mb_y      (s0_mb_y),
		.mb_qscode (s0_mb_qscode),
		.mb_wait
	);

	// Quantiser matrix pass-through
	assign qm_valid  = wr_qmatrix;
	assign qm_intra  = adata[`M2V_QM_INTRA];
	assign qm_custom = adata[`M2V_QM_CUSTOM];
	assign qm_value  = adata[7:0];

	// Side data and signed level from the A operand
	assign s0_data    = adata[`M2V_MVH_WIDTH-1:0];
	assign level_sign = adata[11];
	assign level_data = adata[10:0];

endmodule

// ==== verif/tb_m2v_ctrl.sv ====
// ------------------------------------------------------------
// Testbench for the MPEG-2 decode controller
// Replays the pattern file through the command and host ports
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_m2v_ctrl;

	localparam int TIMEOUT = 50;

	logic        clk;
	logic        reset_n;
	logic        control_address;
	logic        control_read;
	logic [31:0] control_readdata;
	logic        control_write;
	logic [31:0] control_writedata;
	logic        control_readdatavalid;
	logic        irq;
	logic        custom_start;
	logic [2:0]  custom_select;
	logic [15:0] custom_adata;
	logic [15:0] custom_bdata;
	logic        custom_done;
	logic [15:0] custom_result;
	logic [15:0] s0_data;
	logic        pict_valid;
	logic        mvec_h_valid;
	logic        mvec_v_valid;
	logic        s0_valid;
	logic [5:0]  s0_mb_x;
	logic [4:0]  s0_mb_y;
	logic [4:0]  s0_mb_qscode;
	logic [2:0]  s1_block;
	logic        s1_coded;
	logic        ready_isdq;
	logic [5:0]  run;
	logic        level_sign;
	logic [10:0] level_data;
	logic        rl_valid;
	logic        qm_valid;
	logic        qm_custom;
	logic        qm_intra;
	logic [7:0]  qm_value;
	logic        ready_idct;
	logic        ready_mc;
	logic        softreset;
	logic        block_start;
	logic        block_end;
	logic        picture_complete;

	int errors;
	int timeouts;
	int patterns_run;
	bit timed_out;

	m2v_ctrl m2v_ctrl_i (.*);

	always #2 clk = ~clk;

	// Bit order matches the mask column of the pattern file
	function automatic logic [8:0] strobe_mask();
		return {qm_valid, rl_valid, s0_valid, mvec_v_valid, mvec_h_valid, pict_valid,
			picture_complete, block_end, block_start};
	endfunction

	task automatic report_mismatch(input int num, input string name,
		input logic [31:0] got, input logic [31:0] expected);
		errors++;
		$display("ERROR pattern %0d: %s = 0x%0h, expected 0x%0h", num, name, got, expected);
	endtask

	task automatic report_timeout(input int num, input string what);
		timeouts++;
		timed_out = 1'b1;
		$display("Pattern %0d: gave up waiting, %s never came", num, what);
	endtask

	task automatic report_late(input int num, input string what, input int cycles);
		errors++;
		$display("Pattern %0d: %s came %0d cycles later than expected", num, what, cycles);
	endtask

	// ----------------------------------------------------------
	// Command port
	// ----------------------------------------------------------
	task automatic run_command(input int num, input logic [2:0] sel, input logic [15:0] a,
		input logic [15:0] b, input logic [15:0] exp_result, input logic [8:0] exp_mask);
		int wait_cycles;
		custom_start  = 1'b1;
		custom_select = sel;
		custom_adata  = a;
		custom_bdata  = b;
		@(negedge clk);
		custom_start = 1'b0;
		wait_cycles  = 0;
		while (!custom_done && wait_cycles < TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!custom_done) begin
			report_timeout(num, "custom_done");
		end else begin
			// Done belongs in the cycle right after the start
			if (wait_cycles != 0)
				report_late(num, "custom_done", wait_cycles);
			if (custom_result !== exp_result)
				report_mismatch(num, "custom_result", 32'(custom_result), 32'(exp_result));
			if (strobe_mask() !== exp_mask)
				report_mismatch(num, "strobe mask", 32'(strobe_mask()), 32'(exp_mask));
			// Side data is the A operand
			if (|exp_mask[6:3] && s0_data !== a)
				report_mismatch(num, "s0_data", 32'(s0_data), 32'(a));
			// Run from B bits 5..0, signed level from A
			if (exp_mask[7] && run !== b[5:0])
				report_mismatch(num, "run", 32'(run), 32'(b[5:0]));
			if (exp_mask[7] && level_sign !== a[11])
				report_mismatch(num, "level_sign", 32'(level_sign), 32'(a[11]));
			if (exp_mask[7] && level_data !== a[10:0])
				report_mismatch(num, "level_data", 32'(level_data), 32'(a[10:0]));
			if (exp_mask[8] && qm_value !== a[7:0])
				report_mismatch(num, "qm_value", 32'(qm_value), 32'(a[7:0]));
			if (exp_mask[8] && qm_intra !== a[8])
				report_mismatch(num, "qm_intra", 32'(qm_intra), 32'(a[8]));
			if (exp_mask[8] && qm_custom !== a[9])
				report_mismatch(num, "qm_custom", 32'(qm_custom), 32'(a[9]));
			// Done and strobes last exactly one cycle
			@(negedge clk);
			if (custom_done !== 1'b0)
				report_mismatch(num, "custom_done", 32'(custom_done), 32'd0);
			if (strobe_mask() !== 9'd0)
				report_mismatch(num, "strobe mask", 32'(strobe_mask()), 32'd0);
		end
	endtask

	task automatic check_ignored(input int num, input logic [2:0] sel);
		custom_start  = 1'b1;
		custom_select = sel;
		@(negedge clk);
		custom_start = 1'b0;
		repeat (4) begin
			if (custom_done !== 1'b0)
				report_mismatch(num, "custom_done", 32'(custom_done), 32'd0);
			@(negedge clk);
		end
	endtask

	// ----------------------------------------------------------
	// Host port and levels
	// ----------------------------------------------------------
	task automatic host_read(input int num, input logic addr, input logic [31:0] expected);
		int wait_cycles;
		control_address = addr;
		control_read    = 1'b1;
		@(negedge clk);
		control_read = 1'b0;
		wait_cycles  = 0;
		while (!control_readdatavalid && wait_cycles < TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!control_readdatavalid) begin
			report_timeout(num, "control_readdatavalid");
		end else begin
			// Read data is due one cycle after the request
			if (wait_cycles != 0)
				report_late(num, "control_readdatavalid", wait_cycles);
			if (control_readdata !== expected)
				report_mismatch(num, "control_readdata", control_readdata, expected);
		end
	endtask

	task automatic host_write(input logic addr, input logic [31:0] data);
		control_address   = addr;
		control_writedata = data;
		control_write     = 1'b1;
		@(negedge clk);
		control_write = 1'b0;
	endtask

	task automatic check_levels(input int num, input logic [1:0] expected);
		if (irq !== expected[0])
			report_mismatch(num, "irq", 32'(irq), 32'(expected[0]));
		if (softreset !== expected[1])
			report_mismatch(num, "softreset", 32'(softreset), 32'(expected[1]));
	endtask

	task automatic drive_ready(input logic [6:0] value);
		ready_isdq = value[0];
		ready_idct = value[1];
		ready_mc   = value[2];
		s1_coded   = value[3];
		s1_block   = value[6:4];
	endtask

	task automatic check_mb_state(input int num, input logic [5:0] exp_x,
		input logic [4:0] exp_y, input logic [4:0] exp_qscode);
		int wait_cycles;
		// Position keeps wrapping until x is back inside the row
		wait_cycles = 0;
		while ((s0_mb_x !== exp_x || s0_mb_y !== exp_y) && wait_cycles < TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (s0_mb_x !== exp_x)
			report_mismatch(num, "s0_mb_x", 32'(s0_mb_x), 32'(exp_x));
		if (s0_mb_y !== exp_y)
			report_mismatch(num, "s0_mb_y", 32'(s0_mb_y), 32'(exp_y));
		if (s0_mb_qscode !== exp_qscode)
			report_mismatch(num, "s0_mb_qscode", 32'(s0_mb_qscode), 32'(exp_qscode));
	endtask

	task automatic run_pattern(input int num, input logic [31:0] op, input logic [31:0] sel,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] expected,
		input logic [31:0] mask);
		case (op)
			32'h0: run_command(num, sel[2:0], a[15:0], b[15:0], expected[15:0], mask[8:0]);
			32'h1: host_read(num, b[0], expected);
			32'h2: host_write(b[0], expected);
			32'h3: check_levels(num, expected[1:0]);
			32'h4: drive_ready(a[6:0]);
			32'h5: check_mb_state(num, a[5:0], b[4:0], expected[4:0]);
			32'h6: check_ignored(num, sel[2:0]);
			default: begin
				errors++;
				$display("Pattern %0d has an unknown operation code %0h", num, op);
			end
		endcase
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial begin
		int          fd;
		int          status;
		int          fields;
		string       text;
		logic [31:0] op;
		logic [31:0] sel;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expected;
		logic [31:0] mask;
		clk               = 1'b0;
		reset_n           = 1'b0;
		control_address   = 1'b0;
		control_read      = 1'b0;
		control_write     = 1'b0;
		control_writedata = '0;
		custom_start      = 1'b0;
		custom_select     = '0;
		custom_adata      = '0;
		custom_bdata      = '0;
		drive_ready(7'd0);
		errors       = 0;
		timeouts     = 0;
		patterns_run = 0;
		timed_out    = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);

		fd = $fopen("verif/m2v_ctrl_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("The pattern file could not be opened");
		end else begin
			while (!$feof(fd) && !timed_out) begin
				text   = "";
				status = $fgets(text, fd);
				if (status > 0 && text.len() > 1 && text.substr(0, 1) != "//") begin
					fields = $sscanf(text, "%h %h %h %h %h %h", op, sel, a, b, expected, mask);
					patterns_run++;
					if (fields != 6) begin
						errors++;
						$display("Pattern %0d is malformed and was skipped", patterns_run);
					end else begin
						run_pattern(patterns_run, op, sel, a, b, expected, mask);
					end
				end
			end
			$fclose(fd);
		end
		if (patterns_run == 0) begin
			errors++;
			$display("No patterns were read");
		end

		$display("Patterns run: %0d, errors: %0d, timeouts: %0d",
			patterns_run, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verif/m2v_ctrl_patterns.txt ====
// op sel adata bdata expected mask, all hex; op 0 cmd 1 read 2 write 3 irq/softreset
// 4 ready inputs (adata) 5 mb x/y/qscode 6 ignored start; host ops take address in bdata
1 0 0000 0000 00000000 000
3 0 0000 0000 00000002 000
2 0 0000 0000 00000000 000
0 4 0005 0001 00000204 003
0 4 0010 0001 00000204 004
3 0 0000 0000 00000001 000
1 0 0000 0000 01000030 000
0 4 0000 0001 00000004 000
2 0 0000 0000 00000030 000
3 0 0000 0000 00000000 000
1 0 0000 0000 01000000 000
0 4 0048 0001 00000204 000
1 0 0000 0000 01000048 000
2 0 0000 0000 00000048 000
2 0 0000 0000 00000080 000
1 0 0000 0000 00000000 000
3 0 0000 0000 00000002 000
2 0 0000 0000 00000000 000
0 4 22D0 0002 00000000 000
0 4 4240 0002 00000000 000
0 4 8003 0002 00000000 000
1 0 0000 0001 300902D0 000
0 4 1403 0003 00000000 000
0 4 0002 0005 00000000 000
0 4 0014 0007 00000000 000
0 4 0000 0007 00000001 000
5 0 0003 0007 00000000 000
0 4 0000 0007 00000000 000
0 4 0001 0007 00000000 000
5 0 0000 0008 00000000 000
0 4 002B 0006 00000000 000
0 4 0007 0006 00000000 000
5 0 0000 0008 00000007 000
0 4 0040 0006 00000000 000
5 0 0000 0008 0000000B 000
0 4 0065 0006 00000000 000
0 4 0040 0006 00000000 000
5 0 0000 0008 00000005 000
0 4 BEEF 0130 00000000 018
0 4 1234 01C0 00000000 060
0 4 035A 0004 00000000 100
0 4 0110 0004 00000000 100
4 0 005F 0000 00000000 000
0 4 0000 0001 0000037D 000
4 0 0022 0000 00000000 000
0 4 0000 0001 00000294 000
0 0 0ABC 0025 00000000 080
0 0 0123 003F 00000000 080
6 1 0000 0000 00000000 000

// ==== filelist.f ====
+incdir+common
common/m2v_ctrl_pkg.sv
design/m2v_cmd_decode.sv
design/m2v_host_regs.sv
design/m2v_mb_state.sv
design/m2v_ctrl.sv
verif/tb_m2v_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_m2v_ctrl \
	-f filelist.f -o tb_m2v_ctrl || { echo "Build failed"; exit 1; }
./obj_dir/tb_m2v_ctrl > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation PASSED"
